// File: project.f
rtl/mbfPkg.sv
rtl/botInputBuffer.sv
rtl/permutationIterator.sv
rtl/seriesLoader.sv
rtl/varSwapPermuter.sv
rtl/mbfPermutationTop.sv
sim/permutationChecker.sv
sim/tbTop.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tbTop -Mdir obj_dir -f project.f
./obj_dir/VtbTop > sim.log 2>&1
cat sim.log
if grep -q "Test FAILED" sim.log; then
    exit 1
fi

// File: sim/tbTop.sv
`timescale 1ns/1ps

module tbTop;
    import mbfPkg::*;

    localparam int DEPTH_LOG2 = 4;
    localparam int ALMOST_FULL_MARGIN = 2;
    localparam int AF_WRITES = (1 << DEPTH_LOG2) - ALMOST_FULL_MARGIN;

    logic         clk;
    logic         rst;
    mbfT          inBot;
    logic         writeBot;
    logic         almostFull;
    logic         slowDown;
    botBeatT      outBeat;
    logic [127:0] testTag;
    int           checkErrors;
    int           beatCount;
    logic         checkIdle;
    logic [31:0]  lfsr;
    int           tbErrors;
    int           errMark;
    int           waited;
    int           startBeats;

    mbfPermutationTop #(
        .DEPTH_LOG2        (DEPTH_LOG2),
        .ALMOST_FULL_MARGIN(ALMOST_FULL_MARGIN)
    ) u_mbfPermutationTop (.*);

    permutationChecker u_permutationChecker (
        .*,
        .errors(checkErrors),
        .beats (beatCount),
        .idle  (checkIdle)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // right-shift Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
    endfunction

    task automatic writeBots(input int count);
        mbfT b;
        for (int k = 0; k < count; k++) begin
            for (int i = 0; i < 128; i++) begin
                lfsr = lfsrStep(lfsr);
                b[i] = lfsr[0];
            end
            @(posedge clk);
            inBot    <= b;
            writeBot <= 1'b1;
        end
        @(posedge clk);
        writeBot <= 1'b0;
    endtask

    task automatic waitBeats(input int target, input int limit);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (beatCount < target && waited < limit);
        if (beatCount < target) begin
            $display("%0s: no beat %0d within %0d cycles", testTag, target, limit);
            tbErrors++;
        end
    endtask

    task automatic waitIdle(input int limit);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!checkIdle && waited < limit);
        if (!checkIdle) begin
            $display("%0s: bots still outstanding after %0d cycles", testTag, limit);
            tbErrors++;
        end
    endtask

    task automatic finishTest();
        $display("%0s: %0d errors", testTag, checkErrors + tbErrors - errMark);
        errMark = checkErrors + tbErrors;
    endtask

    initial begin
        rst      = 1'b1;
        inBot    = '0;
        writeBot = 1'b0;
        slowDown = 1'b0;
        lfsr     = 32'd62;
        tbErrors = 0;
        errMark  = 0;
        testTag  = "reset";
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (60) @(posedge clk); // spans an end cycle with nothing queued
        finishTest();

        testTag = "single";
        @(posedge clk);
        inBot    <= 128'h2; // only bit 1 set
        writeBot <= 1'b1;
        @(posedge clk);
        writeBot <= 1'b0;
        waitIdle(150);
        finishTest();

        testTag = "burst";
        startBeats = beatCount;
        writeBots(8);
        waitBeats(startBeats + 1, 100);
        waitBeats(startBeats + 8 * 42, 400);
        if (waited != 8 * 42 - 1) begin
            $display("FAILED burst: cycles from first to last beat expected %0d actual %0d",
                8 * 42 - 1, waited);
            tbErrors++;
        end
        waitIdle(20);
        finishTest();

        testTag = "slowdown";
        startBeats = beatCount;
        writeBots(3);
        waitBeats(startBeats + 1, 100);
        @(posedge clk);
        slowDown <= 1'b1;
        repeat (90) @(posedge clk); // at least two end cycles
        @(negedge clk);
        // only the series loaded before slowDown may have come out
        if (beatCount - startBeats != 42) begin
            $display("FAILED slowdown: beats while slowed down expected %0d actual %0d",
                42, beatCount - startBeats);
            tbErrors++;
        end
        @(posedge clk);
        slowDown <= 1'b0;
        waitIdle(300);
        finishTest();

        testTag = "almostfull";
        @(posedge clk);
        slowDown <= 1'b1; // buffer only fills
        waited = 0;
        @(negedge clk);
        while (!almostFull && waited <= AF_WRITES) begin
            writeBots(1);
            waited++;
            @(negedge clk);
        end
        if (!almostFull || waited != AF_WRITES) begin
            $display("FAILED almostfull: writes until almostFull expected %0d actual %0d",
                AF_WRITES, waited);
            tbErrors++;
        end
        @(posedge clk);
        slowDown <= 1'b0;
        waited = 0;
        while (almostFull && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (almostFull) begin
            $display("almostfull: almostFull still high 200 cycles after release");
            tbErrors++;
        end
        waitIdle(AF_WRITES * 42 + 200);
        finishTest();

        $display("summary: %0d beats checked, %0d errors", beatCount, checkErrors + tbErrors);
        if (checkErrors + tbErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: sim/permutationChecker.sv
`timescale 1ns/1ps

module permutationChecker (
    input  logic            clk,
    input  logic            rst,
    input  mbfPkg::mbfT     inBot,
    input  logic            writeBot,
    input  logic            almostFull,
    input  mbfPkg::botBeatT outBeat,
    input  logic [127:0]    testTag,
    output int              errors,
    output int              beats,
    output logic            idle
);
    import mbfPkg::*;

    mbfT expQ [$];
    mbfT curBot;
    mbfT expBot;
    int  beatIdx = 0; // position within the current series
    int  writes = 0;
    int  p6;
    int  p7;
    int  errCount = 0;
    int  beatTotal = 0;
    int  pending = 0;

    assign errors = errCount;
    assign beats  = beatTotal;
    assign idle   = pending == 0 && beatIdx == 0;

    // index i with its bits a and b exchanged
    function automatic int swapIdx(input int i, input int a, input int b);
        if (((i >> a) & 1) == ((i >> b) & 1)) begin
            return i;
        end
        return i ^ ((1 << a) | (1 << b));
    endfunction

    // var 0 <-> var p7 first, then var 1 <-> var 1+p6
    function automatic mbfT refBeat(input mbfT bot, input int sel6, input int sel7);
        mbfT mid;
        mbfT res;
        for (int i = 0; i < 128; i++) begin
            mid[i] = bot[swapIdx(i, 0, sel7)];
        end
        for (int i = 0; i < 128; i++) begin
            res[i] = mid[swapIdx(i, 1, 1 + sel6)];
        end
        return res;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            beatIdx = 0;
        end else begin
            if (writes == 0 && (outBeat.valid || almostFull)) begin
                $display("%0s: outBeat.valid or almostFull high before any write", testTag);
                errCount++;
            end
            if (outBeat.valid) begin
                if (beatIdx == 0) begin
                    if (expQ.size() == 0) begin
                        $display("%0s: valid beat with no bot waiting", testTag);
                        errCount++;
                    end else begin
                        curBot = expQ.pop_front();
                    end
                    p6 = 5;
                    p7 = 6;
                end
                expBot = refBeat(curBot, p6, p7);
                if (outBeat.bot !== expBot) begin
                    $display("FAILED %0s: beat %0d (p6 %0d p7 %0d) expected %h actual %h",
                        testTag, beatIdx, p6, p7, expBot, outBeat.bot);
                    errCount++;
                end
                if (outBeat.seriesLast !== (beatIdx == 41)) begin
                    $display("FAILED %0s: seriesLast at beat %0d expected %0b actual %0b",
                        testTag, beatIdx, beatIdx == 41, outBeat.seriesLast);
                    errCount++;
                end
                beatTotal++;
                beatIdx = beatIdx == 41 ? 0 : beatIdx + 1;
                if (p7 == 0) begin // p7 is the inner count
                    p7 = 6;
                    p6 = p6 == 0 ? 5 : p6 - 1;
                end else begin
                    p7--;
                end
            end else if (beatIdx != 0 || outBeat.seriesLast) begin
                $display("%0s: series broken off after %0d beats", testTag, beatIdx);
                errCount++;
                beatIdx = 0;
            end
            if (writeBot) begin
                expQ.push_back(inBot);
                writes++;
            end
            pending = expQ.size();
        end
    end

endmodule

// File: rtl/mbfPermutationTop.sv
`timescale 1ns/1ps

module mbfPermutationTop #(
    parameter int DEPTH_LOG2 = 4,
    parameter int ALMOST_FULL_MARGIN = 2
) (
    input  logic            clk,
    input  logic            rst,
    input  mbfPkg::mbfT     inBot,
    input  logic            writeBot,
    output logic            almostFull,
    input  logic            slowDown,
    output mbfPkg::botBeatT outBeat
);
    import mbfPkg::*;

    mbfT     headBot;
    logic    notEmpty;
    logic    pop;
    permSelT sel;
    botBeatT loaderBeat;
    permSelT loaderSel;

    botInputBuffer #(
        .DEPTH_LOG2        (DEPTH_LOG2),
        .ALMOST_FULL_MARGIN(ALMOST_FULL_MARGIN)
    ) u_botInputBuffer (
        .clk       (clk),
        .rst       (rst),
        .writeBot  (writeBot),
        .inBot     (inBot),
        .pop       (pop),
        .headBot   (headBot),
        .notEmpty  (notEmpty),
        .almostFull(almostFull)
    );

    permutationIterator u_permutationIterator (
        .clk(clk),
        .rst(rst),
        .sel(sel)
    );

    seriesLoader u_seriesLoader (
        .clk     (clk),
        .rst     (rst),
        .sel     (sel),
        .headBot (headBot),
        .notEmpty(notEmpty),
        .slowDown(slowDown),
        .pop     (pop),
        .beat    (loaderBeat),
        .beatSel (loaderSel)
    );

    varSwapPermuter u_varSwapPermuter (
        .clk    (clk),
        .rst    (rst),
        .inBeat (loaderBeat),
        .inSel  (loaderSel),
        .outBeat(outBeat)
    );

endmodule

// File: rtl/varSwapPermuter.sv
`timescale 1ns/1ps

module varSwapPermuter (
    input  logic            clk,
    input  logic            rst,
    input  mbfPkg::botBeatT inBeat,
    input  mbfPkg::permSelT inSel,
    output mbfPkg::botBeatT outBeat
);
    import mbfPkg::*;

    mbfT swap0 [7];
    mbfT swap1 [6];

    mbfT     s1Bot;
    logic    s1Valid;
    logic    s1Last;
    permIdxT s1P6;

    mbfT  outBot;
    logic outValid;
    logic outLast;

    // stage 1 swaps var 0 with var p7 (k = 0 is the identity)
    for (genvar k = 0; k < 7; k++) begin : gSwap0
        assign swap0[k] = varSwap(inBeat.bot, 3'd0, 3'(k));
    end

    // stage 2 swaps var 1 with var 1+p6
    for (genvar k = 0; k < 6; k++) begin : gSwap1
        assign swap1[k] = varSwap(s1Bot, 3'd1, 3'(k + 1));
    end

    always_ff @(posedge clk) begin
        s1Bot  <= swap0[inSel.p7];
        s1P6   <= inSel.p6;
        outBot <= swap1[s1P6];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid  <= 1'b0;
            s1Last   <= 1'b0;
            outValid <= 1'b0;
            outLast  <= 1'b0;
        end else begin
            s1Valid  <= inBeat.valid;
            s1Last   <= inBeat.seriesLast;
            outValid <= s1Valid;
            outLast  <= s1Last;
        end
    end

    assign outBeat = '{bot: outBot, valid: outValid, seriesLast: outLast};

endmodule

// File: rtl/seriesLoader.sv
`timescale 1ns/1ps

module seriesLoader (
    input  logic            clk,
    input  logic            rst,
    input  mbfPkg::permSelT sel,
    input  mbfPkg::mbfT     headBot,
    input  logic            notEmpty,
    input  logic            slowDown,
    output logic            pop,
    output mbfPkg::botBeatT beat,
    output mbfPkg::permSelT beatSel
);
    import mbfPkg::*;

    logic endCycle;

    mbfT  currentBot;
    logic currentValid;

    mbfT  beatBot;
    logic beatValid;
    logic beatLast;

    // (0, 0) is the last pair of a series
    assign endCycle = sel.p6 == '0 && sel.p7 == '0;

    assign pop = endCycle && !slowDown && notEmpty;

    always_ff @(posedge clk) begin
        if (pop) begin
            currentBot <= headBot;
        end
        beatBot <= currentBot;
        beatSel <= sel; // stays in step with beatBot
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            currentValid <= 1'b0;
            beatValid    <= 1'b0;
            beatLast     <= 1'b0;
        end else begin
            if (endCycle) begin
                currentValid <= pop; // skipped window when slowed down or empty
            end
            beatValid <= currentValid;
            beatLast  <= currentValid && endCycle;
        end
    end

    assign beat = '{bot: beatBot, valid: beatValid, seriesLast: beatLast};

    popOnlyAtEnd: assert property (@(posedge clk) disable iff (rst)
        pop |-> endCycle)
        else $error("seriesLoader: pop outside end cycle");

    // a popped bot stays current for one full 42-beat series
    seriesHeld: assert property (@(posedge clk) disable iff (rst)
        pop |=> currentValid [*42])
        else $error("seriesLoader: series cut short");

endmodule

// File: rtl/permutationIterator.sv
`timescale 1ns/1ps

module permutationIterator (
    input  logic            clk,
    input  logic            rst,
    output mbfPkg::permSelT sel
);
    import mbfPkg::*;

    logic zero6;
    logic zero7;

    assign zero6 = sel.p6 == '0;
    assign zero7 = sel.p7 == '0;

    // p7 is the inner counter, p6 steps once per p7 wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            sel <= '0;
        end else begin
            sel.p7 <= zero7 ? P7_MAX : sel.p7 - 1'b1;
            if (zero7) begin
                sel.p6 <= zero6 ? P6_MAX : sel.p6 - 1'b1;
            end
        end
    end

    // permuter muxes have 7 and 6 inputs
    selInRange: assert property (@(posedge clk) disable iff (rst)
        sel.p7 <= P7_MAX && sel.p6 <= P6_MAX)
        else $error("permutationIterator: index out of range p6=%0d p7=%0d", sel.p6, sel.p7);

endmodule

// File: rtl/botInputBuffer.sv
`timescale 1ns/1ps

module botInputBuffer #(
    parameter int DEPTH_LOG2 = 4,
    parameter int ALMOST_FULL_MARGIN = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        writeBot,
    input  mbfPkg::mbfT inBot,
    input  logic        pop,
    output mbfPkg::mbfT headBot,
    output logic        notEmpty,
    output logic        almostFull
);
    import mbfPkg::*;

    localparam int DEPTH = 1 << DEPTH_LOG2;
    localparam logic [DEPTH_LOG2:0] AF_LEVEL = (DEPTH_LOG2 + 1)'(DEPTH - ALMOST_FULL_MARGIN);
    localparam logic [DEPTH_LOG2:0] FULL_LEVEL = (DEPTH_LOG2 + 1)'(DEPTH);

    mbfT mem [DEPTH];

    logic [DEPTH_LOG2-1:0] wrPtr;
    logic [DEPTH_LOG2-1:0] rdPtr;
    logic [DEPTH_LOG2:0]   count;
    logic [DEPTH_LOG2:0]   nextCount;

    always_ff @(posedge clk) begin
        if (writeBot) begin
            mem[wrPtr] <= inBot;
        end
    end

    always_comb begin
        nextCount = count;
        if (writeBot && !pop) begin
            nextCount = count + 1'b1;
        end else if (pop && !writeBot) begin
            nextCount = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
            almostFull <= 1'b0;
        end else begin
            if (writeBot) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count      <= nextCount;
            almostFull <= nextCount >= AF_LEVEL; // margin left for writes already in flight
        end
    end

    // show-ahead, the head is readable before the pop
    assign headBot  = mem[rdPtr];
    assign notEmpty = count != '0;

    // writer has to respect almostFull
    writeNotFull: assert property (@(posedge clk) disable iff (rst)
        writeBot |-> count != FULL_LEVEL)
        else $error("botInputBuffer: write while full");

    popNotEmpty: assert property (@(posedge clk) disable iff (rst)
        pop |-> notEmpty)
        else $error("botInputBuffer: pop while empty");

endmodule

// File: rtl/mbfPkg.sv
package mbfPkg;

    // truth table of a 7-variable function, bit i holds f(x) with x_k = i[k]
    typedef logic [127:0] mbfT;

    typedef logic [2:0] permIdxT;

    // p6 walks 0..5, p7 walks 0..6
    localparam permIdxT P6_MAX = 3'd5;
    localparam permIdxT P7_MAX = 3'd6;

    typedef struct packed {
        permIdxT p6;
        permIdxT p7;
    } permSelT;

    typedef struct packed {
        mbfT  bot;
        logic valid;
        logic seriesLast; // last of the 42 variants of one bot
    } botBeatT;

    // exchange variables a and b of a truth table
    // out[i] = in[i with bits a and b swapped], a == b leaves it unchanged
    function automatic mbfT varSwap(
        input mbfT     tbl,
        input permIdxT a,
        input permIdxT b
    );
        mbfT        res;
        logic [6:0] dst;
        logic [6:0] src;
        res = '0;
        for (int i = 0; i < 128; i++) begin
            dst = 7'(i);
            src = dst;
            src[a] = dst[b];
            src[b] = dst[a];
            res[i] = tbl[src];
        end
        return res;
    endfunction

endpackage
